//--- Bender.yml
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - mips_regfile.sv
  - mips_decode.sv
  - mips_alu.sv
  - mips_load_align.sv
  - mips_core_ctrl.sv
  - mips_core.sv
  - target: test
    files:
      - mips_core_tb.sv

//--- mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
	input  mips_pkg::alu_op_t op,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  logic [4:0]        shamt,
	output logic [31:0]       result,
	output logic              equal
);
	import mips_pkg::*;

	logic [31:0] diff;

	assign diff = a - b;
	assign equal = (diff == 32'd0); // Branches compare rs and rt.

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_LUI: result = {b[15:0], 16'd0};
			ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
			ALU_SLL: result = b << shamt; // Shifts act on rt.
			ALU_SRL: result = b >> shamt;
			default: result = 32'd0;
		endcase
	end

endmodule

//--- mips_core.sv
`timescale 1ns/1ps

module mips_core #(
	parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] mem_rdata,
	output logic        mem_read,
	output logic        mem_write,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	output logic [3:0]  mem_byteenable,
	output logic [31:0] register_v0,
	output logic        done
);
	import mips_pkg::*;

	decoded_t    dec;
	reg_write_t  reg_write;
	reg_write_t  load_write;
	logic [31:0] instr;
	logic [31:0] read_data_1;
	logic [31:0] read_data_2;
	logic [31:0] merge_data;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic        alu_equal;
	logic        valid_read;

	assign alu_b = dec.use_imm ? dec.imm_ext : read_data_2;

	mips_core_ctrl #(.RESET_PC(RESET_PC)) ctrl0 (
		.clk(clk), .reset(reset), .mem_rdata(mem_rdata), .dec(dec),
		.rs_value(read_data_1), .alu_result(alu_result), .alu_equal(alu_equal),
		.load_write(load_write), .instr(instr), .state(), .mem_read(mem_read),
		.mem_write(mem_write), .mem_addr(mem_addr), .valid_read(valid_read),
		.reg_write(reg_write), .done(done)
	);

	mips_decode decode0 (.instr(instr), .dec(dec));

	// The third port reads rt, which is the store source and the load target.
	mips_regfile regfile0 (
		.clk(clk), .reset(reset), .valid_read(valid_read), .read_addr_1(dec.rs),
		.read_addr_2(dec.rt), .merge_addr(dec.rt), .write(reg_write),
		.read_data_1(read_data_1), .read_data_2(read_data_2), .merge_data(merge_data),
		.register_v0(register_v0)
	);

	mips_alu alu0 (
		.op(dec.alu_op), .a(read_data_1), .b(alu_b), .shamt(dec.shamt),
		.result(alu_result), .equal(alu_equal)
	);

	mips_load_align align0 (
		.kind(dec.mem_kind), .addr_low(mem_addr[1:0]), .store_data(merge_data),
		.load_word(mem_rdata), .dest(dec.rt), .mem_wdata(mem_wdata),
		.mem_byteenable(mem_byteenable), .load_write(load_write)
	);

endmodule

//--- mips_core_ctrl.sv
`timescale 1ns/1ps

module mips_core_ctrl #(
	parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [31:0]            mem_rdata,
	input  mips_pkg::decoded_t     dec,
	input  logic [31:0]            rs_value,
	input  logic [31:0]            alu_result,
	input  logic                   alu_equal,
	input  mips_pkg::reg_write_t   load_write,
	output logic [31:0]            instr,
	output mips_pkg::core_state_t  state,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic [31:0]            mem_addr,
	output logic                   valid_read,
	output mips_pkg::reg_write_t   reg_write,
	output logic                   done
);
	import mips_pkg::*;

	logic [31:0] pc;
	logic [31:0] npc;
	logic [31:0] ir;
	logic [31:0] addr_reg;
	logic [31:0] pc_plus4;
	logic [31:0] next_pc;
	logic        taken;
	logic        is_load;

	assign pc_plus4 = pc + 32'd4;
	assign taken = (dec.branch_eq && alu_equal) || (dec.branch_ne && !alu_equal);
	assign is_load = (dec.mem_kind != MEM_NONE) && !dec.is_store;
	assign next_pc = dec.jump_reg ? rs_value :
		dec.jump ? {pc_plus4[31:28], dec.target, 2'b00} :
		taken ? pc_plus4 + {dec.imm_ext[29:0], 2'b00} : pc_plus4;

	// The fetched word is decoded straight off the bus before the IR holds it.
	assign instr = (state == ST_DECODE) ? mem_rdata : ir;
	assign valid_read = (state == ST_DECODE);
	assign mem_read = (state == ST_FETCH) || (state == ST_MEMORY && !dec.is_store);
	assign mem_write = (state == ST_MEMORY) && dec.is_store;
	assign mem_addr = (state == ST_FETCH) ? pc : addr_reg;

	always_comb begin
		reg_write = '0;
		if (state == ST_WRITEBACK) begin
			if (is_load) begin
				reg_write = load_write;
			end else begin
				reg_write.valid = dec.reg_write;
				reg_write.byteenable = 4'b1111;
				reg_write.addr = dec.link ? LINK_REG : (dec.reg_dst ? dec.rd : dec.rt);
				reg_write.data = dec.link ? pc_plus4 : alu_result;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_HALT; // Leaves halt once since done is still low.
			pc <= RESET_PC;
			done <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: state <= ST_DECODE;
				ST_DECODE: begin
					ir <= mem_rdata;
					state <= ST_EXECUTE;
				end
				ST_EXECUTE: begin
					npc <= next_pc;
					addr_reg <= alu_result;
					state <= (dec.mem_kind != MEM_NONE) ? ST_MEMORY : ST_WRITEBACK;
				end
				ST_MEMORY, ST_WRITEBACK: begin
					if (state == ST_MEMORY && is_load) begin
						state <= ST_WRITEBACK;
					end else begin
						pc <= npc;
						state <= (npc == 32'd0) ? ST_HALT : ST_FETCH;
						done <= (npc == 32'd0);
					end
				end
				default: begin
					if (!done) begin
						state <= ST_FETCH;
					end
				end
			endcase
		end
	end

endmodule

//--- mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;
	localparam logic [31:0] RESET_PC = 32'h0000_1000;
	localparam int PROG_BASE = 32'h0000_1000 >> 2;
	localparam int BODY = 24; // Random instructions between the setup and the checksum fold.

	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  be;
	} access_t;

	logic        clk = 1'b0;
	logic        reset;
	logic [31:0] mem_rdata;
	logic        mem_read;
	logic        mem_write;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_byteenable;
	logic [31:0] register_v0;
	logic        done;

	logic [31:0] mem [4096];
	logic [31:0] mmem [4096];
	logic [31:0] mreg [32];
	logic [31:0] lfsr;
	access_t     exp_q [$];
	logic [31:0] exp_v0;
	int          exp_cycles;
	int          n_instr;
	int          pc_idx;
	int          test_errors;
	int          total_errors;
	int          failed_tests;
	int          tests_run;
	int          wd_cycles;
	int          wd_limit;

	mips_core #(.RESET_PC(RESET_PC)) dut0 (
		.clk(clk), .reset(reset), .mem_rdata(mem_rdata), .mem_read(mem_read),
		.mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_byteenable(mem_byteenable), .register_v0(register_v0), .done(done)
	);

	always #2 clk = ~clk;

	// Memory answers a read one cycle later and writes at the end of the pulse.
	always @(posedge clk) begin
		if (mem_read) begin
			mem_rdata <= mem[mem_addr[13:2]];
		end
		if (mem_write) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (mem_byteenable[lane]) begin
					mem[mem_addr[13:2]][lane*8 +: 8] <= mem_wdata[lane*8 +: 8];
				end
			end
		end
	end

	always @(posedge clk) begin
		wd_cycles = wd_cycles + 1;
		if (wd_cycles > wd_limit) begin
			$display("Timeout after %0d cycles without done", wd_cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Classes: 0 R-type, 1 I-type, 2 store, 3 load, 4 branch, 5 j, 6 jal.
	function automatic int pick_class(input int kind, input int r);
		case (kind)
			0: return (r < 4) ? 0 : 1;
			1: return (r < 3) ? 0 : (r < 5) ? 1 : 2;
			2: return (r < 2) ? 1 : (r < 3) ? 2 : 3;
			default: return (r < 2) ? 1 : (r < 3) ? 2 : (r < 4) ? 3 : (r < 6) ? 4 : r - 1;
		endcase
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] fill_word(input int i);
		return (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]};
	endfunction

	task automatic emit(input logic [31:0] w);
		mem[PROG_BASE + pc_idx] = w;
		pc_idx++;
	endtask

	task automatic gen_program(input int kind);
		logic [5:0]  fns [8];
		logic [5:0]  iops [6];
		logic [5:0]  lops [7];
		logic [4:0]  dst;
		logic [4:0]  src;
		logic [7:0]  off;
		logic [31:0] target;
		int c;
		int k;
		int skip;
		fns = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h00, 6'h02};
		iops = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
		lops = '{6'h20, 6'h24, 6'h21, 6'h25, 6'h23, 6'h22, 6'h26};
		for (int i = 0; i < 4096; i++) begin
			mem[i] = fill_word(i);
		end
		pc_idx = 0;
		emit(enc_i(6'h09, 5'd0, 5'd29, 16'h2000)); // r29 is the data region base.
		while (pc_idx <= BODY) begin
			c = pick_class(kind, next_bits(3));
			dst = 5'd1 + 5'(next_bits(5) % 27);
			src = 5'(next_bits(5));
			off = 8'(next_bits(8));
			skip = next_bits(2) % (BODY - pc_idx + 1);
			target = RESET_PC + 4 * (pc_idx + 1 + skip);
			case (c)
				0: emit(enc_r(src, 5'(next_bits(5)), dst, 5'(next_bits(5)), fns[next_bits(3)]));
				1: emit(enc_i(iops[next_bits(3) % 6], src, dst, 16'(next_bits(16))));
				2: emit(enc_i(next_bits(1) ? 6'h2b : 6'h28, 5'd29, src, {8'd0, off}));
				3: begin
					k = next_bits(3);
					if (k == 7 && pc_idx < BODY) begin
						emit(enc_i(6'h26, 5'd29, dst, {8'd0, off})); // Unaligned word pair.
						emit(enc_i(6'h22, 5'd29, dst, 16'(off) + 16'd3));
					end else begin
						emit(enc_i(lops[k % 7], 5'd29, dst, {8'd0, off}));
					end
				end
				4: emit(enc_i(next_bits(1) ? 6'h04 : 6'h05, src,
					next_bits(1) ? src : dst, 16'(skip)));
				default: emit({(c == 5) ? 6'h02 : 6'h03, target[27:2]});
			endcase
		end
		for (int r = 1; r < 32; r++) begin
			if (r != 2) begin
				emit(enc_r(5'd2, 5'(r), 5'd2, 5'd0, 6'h26)); // Fold every register into v0.
			end
		end
		emit(enc_r(5'd0, 5'd0, 5'd0, 5'd0, 6'h08));
	endtask

	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ea;
		logic [31:0] word;
		logic [31:0] simm;
		logic [1:0]  bo;
		mmem = mem;
		for (int r = 0; r < 32; r++) begin
			mreg[r] = 32'd0;
		end
		exp_q.delete();
		exp_cycles = 0;
		n_instr = 0;
		pc = RESET_PC;
		while (pc != 32'd0 && n_instr < 2000) begin
			w = mmem[pc[13:2]];
			exp_q.push_back('{1'b0, pc, 32'd0, 4'd0});
			a = mreg[w[25:21]];
			b = mreg[w[20:16]];
			simm = {{16{w[15]}}, w[15:0]};
			npc = pc + 32'd4;
			exp_cycles += 4;
			n_instr++;
			case (w[31:26])
				6'h00: begin
					case (w[5:0])
						6'h00: mreg[w[15:11]] = b << w[10:6];
						6'h02: mreg[w[15:11]] = b >> w[10:6];
						6'h08: npc = a;
						6'h21: mreg[w[15:11]] = a + b;
						6'h23: mreg[w[15:11]] = a - b;
						6'h24: mreg[w[15:11]] = a & b;
						6'h25: mreg[w[15:11]] = a | b;
						6'h26: mreg[w[15:11]] = a ^ b;
						6'h2a: mreg[w[15:11]] = {31'd0, $signed(a) < $signed(b)};
						default: ;
					endcase
				end
				6'h09: mreg[w[20:16]] = a + simm;
				6'h0a: mreg[w[20:16]] = {31'd0, $signed(a) < $signed(simm)};
				6'h0c: mreg[w[20:16]] = a & {16'd0, w[15:0]};
				6'h0d: mreg[w[20:16]] = a | {16'd0, w[15:0]};
				6'h0e: mreg[w[20:16]] = a ^ {16'd0, w[15:0]};
				6'h0f: mreg[w[20:16]] = {w[15:0], 16'd0};
				6'h04: npc = (a == b) ? npc + {simm[29:0], 2'b00} : npc;
				6'h05: npc = (a != b) ? npc + {simm[29:0], 2'b00} : npc;
				6'h02: npc = {npc[31:28], w[25:0], 2'b00};
				6'h03: begin
					mreg[31] = pc + 32'd4;
					npc = {npc[31:28], w[25:0], 2'b00};
				end
				6'h2b: begin
					ea = a + simm;
					exp_q.push_back('{1'b1, ea, b, 4'hf});
					mmem[ea[13:2]] = b;
				end
				6'h28: begin
					ea = a + simm;
					exp_q.push_back('{1'b1, ea, {4{b[7:0]}}, 4'b0001 << ea[1:0]});
					mmem[ea[13:2]][8*ea[1:0] +: 8] = b[7:0];
				end
				default: begin
					ea = a + simm;
					bo = ea[1:0];
					word = mmem[ea[13:2]];
					exp_q.push_back('{1'b0, ea, 32'd0, 4'd0});
					exp_cycles += 1; // Loads take a write-back cycle after memory.
					case (w[31:26])
						6'h20: mreg[w[20:16]] = {{24{word[8*bo+7]}}, word[8*bo +: 8]};
						6'h24: mreg[w[20:16]] = {24'd0, word[8*bo +: 8]};
						6'h21: mreg[w[20:16]] = {{16{word[16*bo[1]+15]}}, word[16*bo[1] +: 16]};
						6'h25: mreg[w[20:16]] = {16'd0, word[16*bo[1] +: 16]};
						6'h22: mreg[w[20:16]] = (word << (8 * (3 - bo)))
							| (b & (32'hffff_ffff >> (8 * (bo + 1))));
						6'h26: mreg[w[20:16]] = (word >> (8 * bo))
							| (b & ~(32'hffff_ffff >> (8 * bo)));
						default: mreg[w[20:16]] = word;
					endcase
				end
			endcase
			mreg[0] = 32'd0;
			pc = npc;
		end
		exp_v0 = mreg[2];
	endtask

	task automatic report_value(input string name, input logic [31:0] got, exp);
		$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		test_errors++;
	endtask

	task automatic check_access();
		access_t e;
		if (mem_read && mem_write) begin
			$display("Read and write strobes are both high at %0t", $time);
			test_errors++;
		end
		if (exp_q.size() == 0) begin
			$display("Memory strobe at %0t after the program should have ended", $time);
			test_errors++;
		end else begin
			e = exp_q.pop_front();
			if (mem_write !== e.write) report_value("mem_write", 32'(mem_write), 32'(e.write));
			if (mem_addr !== e.addr) report_value("mem_addr", mem_addr, e.addr);
			if (e.write && mem_wdata !== e.data) report_value("mem_wdata", mem_wdata, e.data);
			if (e.write && mem_byteenable !== e.be) begin
				report_value("mem_byteenable", 32'(mem_byteenable), 32'(e.be));
			end
		end
	endtask

	task automatic run_program(input string name, input int kind);
		int count;
		logic started;
		test_errors = 0;
		gen_program(kind);
		run_model();
		wd_cycles = 0;
		wd_limit = 5 * n_instr + 64;
		@(posedge clk);
		reset <= 1'b1;
		for (int i = 1; i <= 8; i++) begin
			@(posedge clk);
			// The first edge applies reset, so the outputs are cleared from the second on.
			if (i > 1 && (mem_read !== 1'b0 || mem_write !== 1'b0 || done !== 1'b0)) begin
				$display("Strobe or done not low during reset at %0t", $time);
				test_errors++;
			end
			if (i > 1 && register_v0 !== 32'd0) begin
				report_value("register_v0", register_v0, 32'd0);
			end
			if (i == 8) reset <= 1'b0;
		end
		count = 0;
		started = 1'b0;
		do begin
			@(posedge clk);
			if (done !== 1'b1) begin
				if (!started && mem_read === 1'b1 && mem_addr !== RESET_PC) begin
					report_value("first fetch mem_addr", mem_addr, RESET_PC);
				end
				if (mem_read === 1'b1) started = 1'b1;
				if (mem_read || mem_write) check_access();
				if (started) count++;
			end
		end while (done !== 1'b1);
		if (count != exp_cycles) report_value("cycles to done", count, exp_cycles);
		if (exp_q.size() != 0) begin
			$display("%0d expected memory accesses never happened", exp_q.size());
			test_errors++;
		end
		repeat (6) begin
			@(posedge clk);
			if (mem_read !== 1'b0 || mem_write !== 1'b0 || done !== 1'b1) begin
				$display("Core did not stay halted at %0t", $time);
				test_errors++;
			end
		end
		if (register_v0 !== exp_v0) report_value("register_v0", register_v0, exp_v0);
		$display("test %s: %0d instructions, %0d cycles, %0d errors", name, n_instr, count,
			test_errors);
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0) failed_tests++;
	endtask

	initial begin
		reset = 1'b1;
		mem_rdata = 32'd0;
		lfsr = 32'he76f_3525;
		total_errors = 0;
		failed_tests = 0;
		tests_run = 0;
		wd_cycles = 0;
		wd_limit = 1000;
		run_program("alu", 0);
		run_program("stores", 1);
		run_program("loads", 2);
		run_program("control", 3);
		run_program("mixed", 3);
		$display("tests run %0d, failed %0d, errors %0d", tests_run, failed_tests,
			total_errors);
		if (total_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- mips_decode.sv
`timescale 1ns/1ps

module mips_decode (
	input  logic [31:0]        instr,
	output mips_pkg::decoded_t dec
);
	import mips_pkg::*;

	logic [31:0] imm_sign;
	logic [31:0] imm_zero;

	assign imm_sign = {{16{instr[15]}}, instr[15:0]};
	assign imm_zero = {16'd0, instr[15:0]};

	always_comb begin
		dec = '0; // Anything unknown falls through as a no-op.
		dec.rs = instr[25:21];
		dec.rt = instr[20:16];
		dec.rd = instr[15:11];
		dec.shamt = instr[10:6];
		dec.target = instr[25:0];
		dec.imm_ext = imm_sign;
		dec.alu_op = ALU_ADD;
		dec.mem_kind = MEM_NONE;
		case (opcode_t'(instr[31:26]))
			OP_RTYPE: begin
				dec.reg_dst = 1'b1;
				dec.reg_write = 1'b1;
				case (funct_t'(instr[5:0]))
					FN_ADDU: dec.alu_op = ALU_ADD;
					FN_SUBU: dec.alu_op = ALU_SUB;
					FN_AND:  dec.alu_op = ALU_AND;
					FN_OR:   dec.alu_op = ALU_OR;
					FN_XOR:  dec.alu_op = ALU_XOR;
					FN_SLT:  dec.alu_op = ALU_SLT;
					FN_SLL:  dec.alu_op = ALU_SLL;
					FN_SRL:  dec.alu_op = ALU_SRL;
					FN_JR: begin
						dec.reg_write = 1'b0;
						dec.jump_reg = 1'b1;
					end
					default: dec.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: {dec.use_imm, dec.reg_write} = 2'b11;
			OP_SLTI: begin
				{dec.use_imm, dec.reg_write} = 2'b11;
				dec.alu_op = ALU_SLT;
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				{dec.use_imm, dec.reg_write} = 2'b11;
				dec.imm_ext = imm_zero;
				case (instr[27:26])
					2'b00: dec.alu_op = ALU_AND;
					2'b01: dec.alu_op = ALU_OR;
					2'b10: dec.alu_op = ALU_XOR;
					default: dec.alu_op = ALU_LUI;
				endcase
			end
			OP_BEQ: {dec.alu_op, dec.branch_eq} = {ALU_SUB, 1'b1};
			OP_BNE: {dec.alu_op, dec.branch_ne} = {ALU_SUB, 1'b1};
			OP_J: dec.jump = 1'b1;
			OP_JAL: {dec.jump, dec.link, dec.reg_write} = 3'b111; // Writes PC+4 to r31.
			OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LWL, OP_LWR: begin
				{dec.use_imm, dec.reg_write} = 2'b11;
				case (opcode_t'(instr[31:26]))
					OP_LB:   dec.mem_kind = MEM_BYTE_S;
					OP_LBU:  dec.mem_kind = MEM_BYTE_U;
					OP_LH:   dec.mem_kind = MEM_HALF_S;
					OP_LHU:  dec.mem_kind = MEM_HALF_U;
					OP_LWL:  dec.mem_kind = MEM_WORD_L;
					OP_LWR:  dec.mem_kind = MEM_WORD_R;
					default: dec.mem_kind = MEM_WORD;
				endcase
			end
			OP_SW: {dec.use_imm, dec.is_store, dec.mem_kind} = {2'b11, MEM_WORD};
			OP_SB: {dec.use_imm, dec.is_store, dec.mem_kind} = {2'b11, MEM_BYTE_U};
			default: dec.reg_write = 1'b0;
		endcase
	end

endmodule

//--- mips_load_align.sv
`timescale 1ns/1ps

module mips_load_align (
	input  mips_pkg::mem_kind_t   kind,
	input  logic [1:0]            addr_low,
	input  logic [31:0]           store_data,
	input  logic [31:0]           load_word,
	input  logic [4:0]            dest,
	output logic [31:0]           mem_wdata,
	output logic [3:0]            mem_byteenable,
	output mips_pkg::reg_write_t  load_write
);
	import mips_pkg::*;

	logic [31:0] shifted;
	logic [15:0] half;

	assign shifted = load_word >> {addr_low, 3'b000}; // Little-endian lanes.
	assign half = addr_low[1] ? load_word[31:16] : load_word[15:0];

	always_comb begin
		mem_wdata = store_data;
		mem_byteenable = 4'b1111;
		case (kind)
			MEM_BYTE_S, MEM_BYTE_U: begin
				mem_wdata = {4{store_data[7:0]}};
				mem_byteenable = 4'b0001 << addr_low;
			end
			MEM_HALF_S, MEM_HALF_U: begin
				mem_wdata = {2{store_data[15:0]}};
				mem_byteenable = addr_low[1] ? 4'b1100 : 4'b0011;
			end
			default: ;
		endcase
	end

	always_comb begin
		load_write.addr = dest;
		load_write.valid = (kind != MEM_NONE);
		load_write.byteenable = 4'b1111;
		load_write.data = load_word;
		case (kind)
			MEM_BYTE_S: load_write.data = {{24{shifted[7]}}, shifted[7:0]};
			MEM_BYTE_U: load_write.data = {24'd0, shifted[7:0]};
			MEM_HALF_S: load_write.data = {{16{half[15]}}, half};
			MEM_HALF_U: load_write.data = {16'd0, half};
			MEM_WORD_L: begin
				load_write.data = load_word << {~addr_low, 3'b000};
				load_write.byteenable = 4'b1111 << ~addr_low; // Upper bytes only.
			end
			MEM_WORD_R: begin
				load_write.data = shifted;
				load_write.byteenable = 4'b1111 >> addr_low;
			end
			default: ;
		endcase
	end

endmodule

//--- mips_pkg.sv
package mips_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_JAL   = 6'b000011,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_ANDI  = 6'b001100,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_LUI   = 6'b001111,
		OP_LB    = 6'b100000,
		OP_LH    = 6'b100001,
		OP_LWL   = 6'b100010,
		OP_LW    = 6'b100011,
		OP_LBU   = 6'b100100,
		OP_LHU   = 6'b100101,
		OP_LWR   = 6'b100110,
		OP_SB    = 6'b101000,
		OP_SW    = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_JR   = 6'b001000,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_SLT  = 6'b101010
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_LUI, ALU_SLT, ALU_SLL, ALU_SRL
	} alu_op_t;

	typedef enum logic [2:0] {
		MEM_NONE, MEM_WORD, MEM_BYTE_S, MEM_BYTE_U, MEM_HALF_S, MEM_HALF_U, MEM_WORD_L, MEM_WORD_R
	} mem_kind_t;

	typedef enum logic [2:0] {
		ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK, ST_HALT
	} core_state_t;

	typedef struct packed {
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
		logic [31:0] imm_ext;
		logic [25:0] target;
		alu_op_t     alu_op;
		logic        use_imm;
		logic        reg_dst;
		logic        reg_write;
		logic        link;
		mem_kind_t   mem_kind;
		logic        is_store;
		logic        branch_eq;
		logic        branch_ne;
		logic        jump;
		logic        jump_reg;
	} decoded_t;

	typedef struct packed {
		logic [4:0]  addr;
		logic [31:0] data;
		logic [3:0]  byteenable;
		logic        valid;
	} reg_write_t;

	localparam logic [4:0] LINK_REG = 5'd31;
	localparam logic [4:0] V0_REG = 5'd2;

endpackage

//--- mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
	input  logic                clk,
	input  logic                reset,
	input  logic                valid_read,
	input  logic [4:0]          read_addr_1,
	input  logic [4:0]          read_addr_2,
	input  logic [4:0]          merge_addr,
	input  mips_pkg::reg_write_t write,
	output logic [31:0]         read_data_1,
	output logic [31:0]         read_data_2,
	output logic [31:0]         merge_data,
	output logic [31:0]         register_v0
);
	import mips_pkg::*;

	logic [31:0] regs [32];

	assign merge_data = regs[merge_addr]; // Unregistered third port.

	// Each enabled lane is written on its own, so lwl and lwr keep the other bytes.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (write.valid && write.addr != 5'd0) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (write.byteenable[lane]) begin
					regs[write.addr][lane*8 +: 8] <= write.data[lane*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			read_data_1 <= 32'd0;
			read_data_2 <= 32'd0;
		end else if (valid_read) begin
			read_data_1 <= regs[read_addr_1]; // Held until the next decode.
			read_data_2 <= regs[read_addr_2];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			register_v0 <= 32'd0;
		end else begin
			register_v0 <= regs[V0_REG]; // Trails the write edge by one cycle.
		end
	end

endmodule

//--- project.f
mips_pkg.sv
mips_regfile.sv
mips_decode.sv
mips_alu.sv
mips_load_align.sv
mips_core_ctrl.sv
mips_core.sv
mips_core_tb.sv
